// File: bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
   parameter int PERIOD_NS = 100
) (
   output logic clk
);

   // free running dot4x clock, starts low
   initial clk = 1'b0;

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: bench/vicii_checker.sv
`timescale 1ns/10ps

module vicii_checker (
   input logic        clk_dot4x,
   input logic        rst,
   input logic        clk_phi,
   input logic [15:0] phase_start,
   input logic        ba,
   input logic        aec
);

   // high phase ends seen in a row with ba low, saturates at three
   logic [1:0]  ba_low_phases;
   int unsigned failures = 0;

   always_ff @(posedge clk_dot4x) begin
      if (rst)
         ba_low_phases <= 2'd0;
      else if (clk_phi && phase_start[15])
         ba_low_phases <= ba ? 2'd0 :
                          (ba_low_phases == 2'd3) ? 2'd3 : ba_low_phases + 2'd1;
   end

   // the cpu only ever gets the bus in phi high
   aec_only_in_phi_high: assert property (@(posedge clk_dot4x) disable iff (rst)
      !clk_phi |-> !aec)
   else begin
      $error("aec high while clk_phi is low");
      failures++;
   end

   // three high phases of grace after ba falls, the fourth is ours
   aec_released_after_ba: assert property (@(posedge clk_dot4x) disable iff (rst)
      (ba_low_phases == 2'd3 && !ba && clk_phi) |-> !aec)
   else begin
      $error("aec still high in the fourth phi high phase after ba fell");
      failures++;
   end

   // phase ring must never lose or gain a bit
   phase_ring_onehot: assert property (@(posedge clk_dot4x) disable iff (rst)
      $onehot(phase_start))
   else begin
      $error("phase_start is not one-hot");
      failures++;
   end

endmodule

bind bus_arbiter vicii_checker u_checker (
   .clk_dot4x   (clk_dot4x),
   .rst         (rst),
   .clk_phi     (clk_phi),
   .phase_start (phase_start),
   .ba          (ba),
   .aec         (aec)
);

// File: bench/vicii_tb.sv
`timescale 1ns/10ps

module vicii_tb
   import vic_pkg::*;
();

   localparam int CLK_PERIOD_NS = 100;
   // a 6567R8 line is 65 cycles of 32 ticks
   localparam int LINE_TICKS = 2080;
   // tests end near line 53 so sixty lines leave room
   localparam longint TIMEOUT_NS = longint'(60 * LINE_TICKS + 4000) * CLK_PERIOD_NS;

   logic       clk;
   logic       rst;
   logic       ce;
   logic       rw;
   logic [5:0] adi;
   logic [7:0] dbi;
   logic       clk_phi;
   logic [9:0] raster_x;
   logic [8:0] raster_line;
   logic [7:0] dbo;
   logic       irq;
   logic       ba;
   logic       aec;
   logic       ras;
   logic       cas;
   logic       ls245_data_dir;
   logic       vic_write_db;
   logic       vic_write_ab;

   int          checks;
   int          errors;
   logic [31:0] lcg_state;

   tb_clock #(
      .PERIOD_NS (CLK_PERIOD_NS)
   ) u_clock (
      .clk (clk)
   );

   vicii_top #(
      .CHIP (CHIP6567R8)
   ) UUT (
      .clk_dot4x      (clk),
      .rst            (rst),
      .ce             (ce),
      .rw             (rw),
      .adi            (adi),
      .dbi            (dbi),
      .clk_phi        (clk_phi),
      .raster_x       (raster_x),
      .raster_line    (raster_line),
      .dbo            (dbo),
      .irq            (irq),
      .ba             (ba),
      .aec            (aec),
      .ras            (ras),
      .cas            (cas),
      .ls245_data_dir (ls245_data_dir),
      .vic_write_db   (vic_write_db),
      .vic_write_ab   (vic_write_ab)
   );

   // upper lcg bits are the better ones
   function automatic logic [7:0] random_byte();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   // returns on the first falling edge that sees clk_phi at level
   task automatic wait_phi(input logic level);
      @(negedge clk);
      while (clk_phi !== level)
         @(negedge clk);
   endtask

   // held over a whole high phase so the late write strobe is covered
   task automatic cpu_write(input logic [5:0] addr, input logic [7:0] data);
      wait_phi(1'b0);
      wait_phi(1'b1);
      ce  = 1'b0;
      rw  = 1'b0;
      adi = addr;
      dbi = data;
      wait_phi(1'b0);
      ce = 1'b1;
      rw = 1'b1;
   endtask

   // dbo is registered with one tick of latency
   task automatic cpu_read(input logic [5:0] addr, output logic [7:0] data);
      ce  = 1'b0;
      rw  = 1'b1;
      adi = addr;
      @(negedge clk);
      data = dbo;
      ce   = 1'b1;
   endtask

   task automatic wait_irq(input logic level, input int max_ticks);
      int n;
      n = 0;
      while (irq !== level && n < max_ticks) begin
         @(negedge clk);
         n++;
      end
      check_value(irq, level, "irq level after wait");
   endtask

   // buffer control follows the bus owner and the cpu cycle type
   task automatic check_bus_dir();
      if (aec && !ce && rw) begin
         check_value(vic_write_db, 1'b1, "vic_write_db on cpu read");
         check_value(ls245_data_dir, 1'b0, "ls245_data_dir on cpu read");
      end
      if (ce)
         check_value(vic_write_db, 1'b0, "vic_write_db with ce high");
      check_value(vic_write_ab, !aec, "vic_write_ab against aec");
   endtask

   function automatic int probe(input logic sel_line);
      if (sel_line)
         return raster_line;
      return raster_x;
   endfunction

   // ticks between two changes of raster_x or raster_line
   task automatic ticks_per_step(input logic sel_line, output int n);
      int prev;
      prev = probe(sel_line);
      while (probe(sel_line) == prev)
         @(negedge clk);
      prev = probe(sel_line);
      n    = 0;
      while (probe(sel_line) == prev) begin
         @(negedge clk);
         n++;
      end
   endtask

   task automatic phi_phase_ticks(input logic level, output int n);
      wait_phi(!level);
      wait_phi(level);
      n = 0;
      while (clk_phi === level) begin
         @(negedge clk);
         n++;
      end
   endtask

   task automatic test_reset_state();
      check_value(raster_line, 0, "raster_line after reset");
      check_value(irq, 1'b0, "irq after reset");
      check_value(ba, 1'b1, "ba after reset");
      check_value(aec, 1'b0, "aec after reset");
      check_value(ras, 1'b1, "ras after reset");
      check_value(cas, 1'b1, "cas after reset");
   endtask

   task automatic test_register_access();
      logic [7:0] en_val;
      logic [7:0] c1_val;
      logic [7:0] rd;
      en_val = random_byte();
      c1_val = random_byte();
      cpu_write(REG_IRQ_ENABLE, en_val);
      cpu_write(REG_CTRL1, c1_val);
      cpu_read(REG_IRQ_ENABLE, rd);
      check_value(rd[0], en_val[0], "irq enable readback");
      cpu_read(REG_CTRL1, rd);
      check_value(rd[6:0], c1_val[6:0], "ctrl1 readback");
      // the delayed line copy has caught up by mid line
      // line 1 keeps the readback apart from the zero compare value
      while (raster_line != 9'd1 || raster_x != 10'd200)
         @(negedge clk);
      cpu_read(REG_RASTER, rd);
      check_value(rd, raster_line[7:0], "raster register readback");
      cpu_write(REG_IRQ_ENABLE, 8'h00);
   endtask

   task automatic test_raster_irq();
      int         target;
      int         irq_highs;
      logic [7:0] rd;
      target = 3 + (random_byte() % 18);
      cpu_write(REG_CTRL1, 8'h00);
      cpu_write(REG_RASTER, 8'(target));
      // drop anything latched on earlier lines
      cpu_write(REG_IRQ_STATUS, 8'h01);
      cpu_read(REG_IRQ_STATUS, rd);
      check_value(rd[0], 1'b0, "raster status before compare line");
      check_value(raster_line < target, 1, "compare line still ahead");
      irq_highs = 0;
      while (raster_line != target || raster_x != 10'd100) begin
         @(negedge clk);
         if (irq)
            irq_highs++;
      end
      cpu_read(REG_IRQ_STATUS, rd);
      check_value(rd[0], 1'b1, "raster status on compare line");
      check_value(rd[7], 1'b0, "irq bit with enable off");
      check_value(irq_highs, 0, "irq ticks with enable off");
      cpu_write(REG_IRQ_ENABLE, 8'h01);
      wait_irq(1'b1, 64);
      // acknowledged status must not come back on this line
      cpu_write(REG_IRQ_STATUS, 8'h01);
      wait_irq(1'b0, 64);
      irq_highs = 0;
      while (raster_line == target) begin
         @(negedge clk);
         if (irq)
            irq_highs++;
      end
      check_value(irq_highs, 0, "irq ticks after acknowledge");
      cpu_write(REG_IRQ_ENABLE, 8'h00);
   endtask

   task automatic test_timing();
      int n;
      phi_phase_ticks(1'b1, n);
      check_value(n, PHI_TICKS / 2, "clk_phi high ticks");
      phi_phase_ticks(1'b0, n);
      check_value(n, PHI_TICKS / 2, "clk_phi low ticks");
      repeat (3) begin
         ticks_per_step(1'b0, n);
         check_value(n, 4, "ticks per raster_x step");
      end
      ticks_per_step(1'b1, n);
      check_value(n, LINE_TICKS, "ticks per raster line");
   endtask

   task automatic test_bus_direction();
      int aec_highs;
      aec_highs = 0;
      wait_phi(1'b0);
      ce  = 1'b0;
      rw  = 1'b1;
      adi = REG_RASTER;
      repeat (PHI_TICKS * 2) begin
         @(negedge clk);
         if (aec)
            aec_highs++;
         check_bus_dir();
      end
      check_value(aec_highs > 0, 1, "cpu got the bus during read window");
      ce = 1'b1;
      repeat (PHI_TICKS * 2) begin
         @(negedge clk);
         check_bus_dir();
      end
   endtask

   task automatic test_badline();
      logic [7:0] rnd;
      int         ba_lows;
      int         aec_lows;
      rnd = random_byte();
      // den on, yscroll 3, mode bits random, compare bit 8 clear
      cpu_write(REG_CTRL1, {1'b0, rnd[6:5], 1'b1, rnd[3], 3'd3});
      check_value(raster_line < BADLINE_FIRST, 1, "den set before line 48");
      while (raster_line != 9'd51)
         @(negedge clk);
      ba_lows  = 0;
      aec_lows = 0;
      while (raster_line == 9'd51) begin
         if (!ba)
            ba_lows++;
         if (ba_lows > 0 && clk_phi && !aec)
            aec_lows++;
         check_bus_dir();
         @(negedge clk);
      end
      check_value(ba_lows > 0, 1, "ba low on line 51");
      check_value(aec_lows > 0, 1, "aec low in phi high on line 51");
      ba_lows = 0;
      while (raster_line == 9'd52) begin
         if (!ba)
            ba_lows++;
         check_bus_dir();
         @(negedge clk);
      end
      check_value(ba_lows, 0, "ba low ticks on line 52");
   endtask

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("Regression failed");
      $finish;
   end

   initial begin
      checks    = 0;
      errors    = 0;
      lcg_state = 32'd78;
      rst       = 1'b1;
      ce        = 1'b1;
      rw        = 1'b1;
      adi       = '0;
      dbi       = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      test_reset_state();
      test_register_access();
      test_raster_irq();
      test_timing();
      test_bus_direction();
      test_badline();
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, UUT.u_bus_arbiter.u_checker.failures);
      if (errors == 0 && UUT.u_bus_arbiter.u_checker.failures == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: rtl/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter import vic_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  logic        clk_phi,
   input  logic [15:0] phase_start,
   input  logic [8:0]  raster_line_d,
   input  logic [9:0]  xpos,
   input  ctrl1_reg    ctrl1,
   input  logic        ce,
   input  logic        rw,
   output logic        ba,
   output logic        aec,
   output logic        ls245_data_dir,
   output logic        vic_write_db,
   output logic        vic_write_ab
);

   logic     allow_bad_lines;
   // ctrl1 as seen at the last high phase start
   ctrl1_reg ctrl1_d;
   logic     badline;
   logic     ba1;
   logic     ba2;
   logic     ba3;
   // value clk_phi takes on the next tick
   logic     phi_next;

   // den only counts if seen on the first line of the window
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
         ctrl1_d         <= '0;
      end else if (clk_phi && phase_start[0]) begin
         ctrl1_d <= ctrl1;
         if (raster_line_d == BADLINE_FIRST && ctrl1.f.den)
            allow_bad_lines <= 1'b1;
         if (raster_line_d == BADLINE_LAST)
            allow_bad_lines <= 1'b0;
      end
   end

   // bad line when the low line bits match yscroll inside the window
   assign badline = allow_bad_lines &&
                    (raster_line_d >= BADLINE_FIRST) &&
                    (raster_line_d < BADLINE_LAST) &&
                    (raster_line_d[2:0] == ctrl1_d.f.yscroll);

   // window wraps through xpos 0, hence the or
   assign ba = !(badline && (xpos >= CHARS_BA_START || xpos < CHARS_BA_END));

   // ba history sampled at the end of each high phase
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1 <= 1'b1;
         ba2 <= 1'b1;
         ba3 <= 1'b1;
      end else if (clk_phi && phase_start[15]) begin
         ba1 <= ba;
         ba2 <= ba1 | ba;
         ba3 <= ba2 | ba;
      end
   end

   // registered aec tracks phi without a tick of skew
   assign phi_next = phase_start[15] ? !clk_phi : clk_phi;

   // cpu keeps three more high phases after ba falls
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         aec <= 1'b0;
      else
         aec <= ba ? phi_next : (ba3 & phi_next);
   end

   // LS245 dir low drives B to A, the chip drives data on a cpu read
   assign vic_write_db   = aec && rw && !ce;
   assign ls245_data_dir = !vic_write_db;
   // address bus belongs to us whenever the cpu is off it
   assign vic_write_ab   = !aec;

endmodule

// File: rtl/phase_gen.sv
`timescale 1ns/10ps

module phase_gen import vic_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   output logic        clk_phi,
   output logic        dot_tick,
   output logic [15:0] phase_start,
   output logic        ras,
   output logic        cas
);

   // reset puts phi three ticks into its low phase
   localparam logic [PHI_TICKS-1:0] PHI_INIT = 32'h000f_fff0;
   // ras falls two ticks after reload, cas two ticks later
   // both rise again near the end of the phase
   localparam logic [15:0] RAS_PROFILE = 16'b1100_0000_0000_0111;
   localparam logic [15:0] CAS_PROFILE = 16'b1111_0000_0000_0011;

   logic [PHI_TICKS-1:0] phi_gen;
   logic [3:0]           dot_ring;
   logic [15:0]          ras_gen;
   logic [15:0]          cas_gen;

   // all rings rotate toward the msb
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_gen     <= PHI_INIT;
         dot_ring    <= 4'b1000;
         phase_start <= 16'b0000_0000_0000_1000;
      end else begin
         phi_gen     <= {phi_gen[PHI_TICKS-2:0], phi_gen[PHI_TICKS-1]};
         dot_ring    <= {dot_ring[2:0], dot_ring[3]};
         phase_start <= {phase_start[14:0], phase_start[15]};
      end
   end

   // phase_start[0] lines up with the first tick of every phi phase
   assign clk_phi  = phi_gen[0];
   // one tick per pixel, on the rising dot edge
   assign dot_tick = dot_ring[0];

   // dram strobe profiles, reloaded once per phase
   always_ff @(posedge clk_dot4x) begin
      if (rst || phase_start[2]) begin
         ras_gen <= RAS_PROFILE;
         cas_gen <= CAS_PROFILE;
      end else begin
         ras_gen <= {ras_gen[14:0], 1'b0};
         cas_gen <= {cas_gen[14:0], 1'b0};
      end
   end

   // strobes are taken from the top bit of each profile
   assign ras = ras_gen[15];
   assign cas = cas_gen[15];

endmodule

// File: rtl/raster_counter.sv
`timescale 1ns/10ps

module raster_counter import vic_pkg::*; #(
   parameter chip_type CHIP = CHIP6567R8
) (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  logic        dot_tick,
   input  logic        clk_phi,
   input  logic [15:0] phase_start,
   output logic [9:0]  raster_x,
   output logic [9:0]  xpos,
   output logic [8:0]  raster_line,
   output logic [8:0]  raster_line_d,
   output logic [6:0]  cycle_num
);

   // line length and line count per chip, unused code acts as 6569
   localparam logic [9:0] X_MAX = (CHIP == CHIP6567R8)   ? 10'd519 :
                                  (CHIP == CHIP6567R56A) ? 10'd511 : 10'd503;
   localparam logic [8:0] Y_MAX = (CHIP == CHIP6567R8)   ? 9'd262 :
                                  (CHIP == CHIP6567R56A) ? 9'd261 : 9'd311;
   // xpos range and its value in cycle 0
   localparam logic [9:0] XPOS_MAX   = (CHIP == CHIP6569 || CHIP == CHIPUNUSED) ?
                                       10'h1f7 : 10'h1ff;
   localparam logic [9:0] XPOS_START = (CHIP == CHIP6569 || CHIP == CHIPUNUSED) ?
                                       10'h194 : 10'h19c;

   logic xpos_hold;

   // eight pixels per cycle
   assign cycle_num = raster_x[9:3];

   // 6567R8 has 520 pixels but only 512 xpos values,
   // xpos stays at $184 for one extra cycle
   assign xpos_hold = (CHIP == CHIP6567R8) && (cycle_num == 7'd61);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x    <= '0;
         xpos        <= XPOS_START;
         raster_line <= '0;
      end else if (dot_tick) begin
         if (raster_x == X_MAX) begin
            // end of line, xpos is reloaded to stay locked to raster_x
            raster_x    <= '0;
            xpos        <= XPOS_START;
            raster_line <= (raster_line == Y_MAX) ? 9'd0 : raster_line + 9'd1;
         end else begin
            raster_x <= raster_x + 10'd1;
            if (!xpos_hold)
               xpos <= (xpos == XPOS_MAX) ? 10'd0 : xpos + 10'd1;
         end
      end
   end

   // line changes at a low phase start, the copy follows at the next high phase
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         raster_line_d <= '0;
      else if (clk_phi && phase_start[0])
         raster_line_d <= raster_line;
   end

endmodule

// File: rtl/raster_irq.sv
`timescale 1ns/10ps

module raster_irq (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  logic        clk_phi,
   input  logic [15:0] phase_start,
   input  logic [8:0]  raster_line_d,
   input  logic [8:0]  raster_compare,
   output logic        irst
);

   // set once the current line has raised its condition
   logic triggered;

   // compare on the second tick of each high phase,
   // raster_line_d has just been updated there
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst      <= 1'b0;
         triggered <= 1'b0;
      end else begin
         // condition is a single tick pulse
         irst <= 1'b0;
         if (clk_phi && phase_start[1]) begin
            if (raster_line_d == raster_compare) begin
               if (!triggered) begin
                  triggered <= 1'b1;
                  irst      <= 1'b1;
               end
            end else begin
               // line moved on, arm for the next match
               triggered <= 1'b0;
            end
         end
      end
   end

endmodule

// File: rtl/vic_pkg.sv
package vic_pkg;

   // chip variants, selects line length and line count
   typedef enum logic [1:0] {
      CHIP6567R8,
      CHIP6567R56A,
      CHIP6569,
      CHIPUNUSED
   } chip_type;

   // fields of the $d011 control byte, msb first
   typedef struct packed {
      // raster compare bit 8 on write
      logic       rst8;
      // extended color mode
      logic       ecm;
      // bitmap mode
      logic       bmm;
      // display enable
      logic       den;
      // 24/25 row select
      logic       rsel;
      // vertical fine scroll
      logic [2:0] yscroll;
   } ctrl1_fields;

   // cpu writes the raw byte, the rest of the chip reads the fields
   typedef union packed {
      logic [7:0]  raw;
      ctrl1_fields f;
   } ctrl1_reg;

   // register offsets on the 6-bit cpu address bus
   localparam logic [5:0] REG_CTRL1      = 6'h11;
   localparam logic [5:0] REG_RASTER     = 6'h12;
   localparam logic [5:0] REG_IRQ_STATUS = 6'h19;
   localparam logic [5:0] REG_IRQ_ENABLE = 6'h1a;

   // bad lines may only occur inside this line range
   localparam logic [8:0] BADLINE_FIRST = 9'd48;
   localparam logic [8:0] BADLINE_LAST  = 9'd248;

   // xpos range where ba is held low for c-accesses
   // start is cycle 12, three cycles ahead of the first c-access
   // window wraps through xpos 0
   localparam logic [9:0] CHARS_BA_START = 10'h1f4;
   localparam logic [9:0] CHARS_BA_END   = 10'h14c;

   // dot4x ticks in one full phi cycle
   localparam int PHI_TICKS = 32;

endpackage

// File: rtl/vic_registers.sv
`timescale 1ns/10ps

module vic_registers import vic_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   input  logic        clk_phi,
   input  logic [15:0] phase_start,
   input  logic        ce,
   input  logic        rw,
   input  logic [5:0]  adi,
   input  logic [7:0]  dbi,
   output logic [7:0]  dbo,
   input  logic [8:0]  raster_line_d,
   input  logic        irst,
   output logic        irq,
   output ctrl1_reg    ctrl1,
   output logic [8:0]  raster_compare
);

   // low byte of the raster compare value
   logic [7:0] compare_lo;
   // latched raster interrupt, $d019 bit 0
   logic       irst_status;
   // raster interrupt enable, $d01a bit 0
   logic       erst;
   logic       reg_write;
   logic       status_clr;

   // cpu data is valid late in the high phase
   assign reg_write  = clk_phi && phase_start[15] && !ce && !rw;
   // writing a one to bit 0 acknowledges the interrupt
   assign status_clr = reg_write && (adi == REG_IRQ_STATUS) && dbi[0];

   // bit 7 of ctrl1 doubles as compare bit 8
   assign raster_compare = {ctrl1.f.rst8, compare_lo};

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1.raw  <= '0;
         compare_lo <= '0;
         erst       <= 1'b0;
      end else if (reg_write) begin
         case (adi)
            REG_CTRL1:      ctrl1.raw  <= dbi;
            REG_RASTER:     compare_lo <= dbi;
            REG_IRQ_ENABLE: erst       <= dbi[0];
            default: ;
         endcase
      end
   end

   // status latches the compare pulse whether or not it is enabled,
   // an acknowledge in the same tick wins
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         irst_status <= 1'b0;
      else if (status_clr)
         irst_status <= 1'b0;
      else if (irst)
         irst_status <= 1'b1;
   end

   // irq pin lags the status by one tick
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         irq <= 1'b0;
      else
         irq <= irst_status & erst;
   end

   // read data, sampled every tick of a cpu read
   // unused bits read back as ones
   always_ff @(posedge clk_dot4x) begin
      if (!ce && rw) begin
         case (adi)
            // bit 7 reads the current line instead of the compare bit
            REG_CTRL1:      dbo <= {raster_line_d[8], ctrl1.raw[6:0]};
            REG_RASTER:     dbo <= raster_line_d[7:0];
            REG_IRQ_STATUS: dbo <= {irq, 6'b111111, irst_status};
            REG_IRQ_ENABLE: dbo <= {7'b1111111, erst};
            default:        dbo <= 8'hff;
         endcase
      end
   end

endmodule

// File: rtl/vicii_top.sv
`timescale 1ns/10ps

module vicii_top import vic_pkg::*; #(
   parameter chip_type CHIP = CHIP6567R8
) (
   input  logic       clk_dot4x,
   input  logic       rst,
   input  logic       ce,
   input  logic       rw,
   input  logic [5:0] adi,
   input  logic [7:0] dbi,
   output logic       clk_phi,
   output logic [9:0] raster_x,
   output logic [8:0] raster_line,
   output logic [7:0] dbo,
   output logic       irq,
   output logic       ba,
   output logic       aec,
   output logic       ras,
   output logic       cas,
   output logic       ls245_data_dir,
   output logic       vic_write_db,
   output logic       vic_write_ab
);

   logic        dot_tick;
   logic [15:0] phase_start;
   logic [9:0]  xpos;
   logic [8:0]  raster_line_d;
   logic [8:0]  raster_compare;
   logic        irst;
   ctrl1_reg    ctrl1;

   // phi, dot and dram strobes
   phase_gen u_phase_gen (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .clk_phi     (clk_phi),
      .dot_tick    (dot_tick),
      .phase_start (phase_start),
      .ras         (ras),
      .cas         (cas)
   );

   // beam position, cycle number stays internal
   raster_counter #(
      .CHIP (CHIP)
   ) u_raster_counter (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .dot_tick      (dot_tick),
      .clk_phi       (clk_phi),
      .phase_start   (phase_start),
      .raster_x      (raster_x),
      .xpos          (xpos),
      .raster_line   (raster_line),
      .raster_line_d (raster_line_d),
      .cycle_num     ()
   );

   // cpu side registers and irq pin
   vic_registers u_vic_registers (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .clk_phi        (clk_phi),
      .phase_start    (phase_start),
      .ce             (ce),
      .rw             (rw),
      .adi            (adi),
      .dbi            (dbi),
      .dbo            (dbo),
      .raster_line_d  (raster_line_d),
      .irst           (irst),
      .irq            (irq),
      .ctrl1          (ctrl1),
      .raster_compare (raster_compare)
   );

   // raster compare condition
   raster_irq u_raster_irq (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .clk_phi        (clk_phi),
      .phase_start    (phase_start),
      .raster_line_d  (raster_line_d),
      .raster_compare (raster_compare),
      .irst           (irst)
   );

   // badline, ba/aec and bus buffer control
   bus_arbiter u_bus_arbiter (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .clk_phi        (clk_phi),
      .phase_start    (phase_start),
      .raster_line_d  (raster_line_d),
      .xpos           (xpos),
      .ctrl1          (ctrl1),
      .ce             (ce),
      .rw             (rw),
      .ba             (ba),
      .aec            (aec),
      .ls245_data_dir (ls245_data_dir),
      .vic_write_db   (vic_write_db),
      .vic_write_ab   (vic_write_ab)
   );

endmodule

// File: sources.f
rtl/vic_pkg.sv
rtl/phase_gen.sv
rtl/raster_counter.sv
rtl/vic_registers.sv
rtl/raster_irq.sv
rtl/bus_arbiter.sv
rtl/vicii_top.sv
bench/tb_clock.sv
bench/vicii_checker.sv
bench/vicii_tb.sv
